/* valu_lite.f */
+incdir+logic
logic/valu_pkg.sv
logic/valu_bitwise_unit.sv
logic/valu_arith_unit.sv
logic/valu_resp_merge.sv
logic/valu_top.sv
bench/valu_asserts.sv
bench/valu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module valu_tb -f valu_lite.f --Mdir obj_dir -o valu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past the first assertion error so the testbench reaches its summary
sim_out=$(./obj_dir/valu_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* bench/valu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "valu_config.svh"

module valu_tb;

    import valu_pkg::*;

    localparam int QUIET_CYCLES = `VALU_LATENCY + 3;  // last slot plus its check edge
    localparam int WAIT_LIMIT   = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    valu_op_e    req_op;
    valu_sew_e   req_sew;
    valu_data_t  req_data0;
    valu_data_t  req_data1;
    valu_be_t    req_be;
    valu_addr_t  req_addr;
    logic        req_start;
    logic        req_end;
    logic        resp_valid;
    valu_data_t  resp_data;
    valu_be_t    resp_be;
    valu_addr_t  resp_addr;
    logic        resp_start;
    logic        resp_end;
    logic [31:0] lcg_state;
    int          tests_passed;
    int          tests_failed;
    int          err_base;

    valu_top valu_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic valu_data_t rand_data();
        valu_data_t d;
        d[63:32] = lcg_next();
        d[31:0]  = lcg_next();
        return d;
    endfunction

    task automatic clear_req();
        req_valid = 1'b0;
        req_op    = OP_AND;
        req_sew   = SEW_8;
        req_data0 = '0;
        req_data1 = '0;
        req_be    = '0;
        req_addr  = '0;
        req_start = 1'b0;
        req_end   = 1'b0;
    endtask

    task automatic send(input valu_op_e op, input valu_sew_e sew,
                        input valu_data_t d0, input valu_data_t d1);
        logic [31:0] side;
        side = lcg_next();
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_op    = op;
        req_sew   = sew;
        req_data0 = d0;
        req_data1 = d1;
        req_be    = side[31:24];  // upper lcg bits
        req_start = side[23];
        req_end   = side[22];
        req_addr  = lcg_next();
    endtask

    // go idle, wait until the response stream stays quiet, then score the test
    task automatic end_test(input string name);
        int quiet;
        int waited;
        int errs;
        quiet  = 0;
        waited = 0;
        @(posedge clk);
        #1;
        clear_req();
        while (quiet < QUIET_CYCLES && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            quiet = resp_valid ? 0 : quiet + 1;
        end
        errs     = valu_top_i.asserts_i.fail_count - err_base;
        err_base = valu_top_i.asserts_i.fail_count;
        if (quiet < QUIET_CYCLES) begin
            $display("%s: timed out waiting for resp_valid to stay low", name);
            errs++;
        end
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failures", name, errs);
        end
    endtask

    initial begin
        valu_op_e    op;
        valu_sew_e   sew;
        logic [31:0] r;
        clk          = 1'b0;
        rst          = 1'b1;
        lcg_state    = 32'd62032;
        tests_passed = 0;
        tests_failed = 0;
        err_base     = 0;
        clear_req();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (8) @(posedge clk);
        end_test("reset_idle");

        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 3; o++) begin
                op  = valu_op_e'(4'(o));
                sew = valu_sew_e'(2'(s));
                repeat (4) send(op, sew, rand_data(), rand_data());
            end
        end
        end_test("bitwise");

        for (int s = 0; s < 4; s++) begin
            for (int o = 3; o < 6; o++) begin
                op  = valu_op_e'(4'(o));
                sew = valu_sew_e'(2'(s));
                send(op, sew, '1, 64'h0101_0101_0101_0101);  // carries stop at elements
                send(op, sew, 64'h0001_0001_0001_0001, '1);
                send(op, sew, '1, '1);
                repeat (3) send(op, sew, rand_data(), rand_data());
            end
        end
        end_test("add_sub");

        for (int s = 0; s < 4; s++) begin
            for (int o = 6; o < 10; o++) begin
                op  = valu_op_e'(4'(o));
                sew = valu_sew_e'(2'(s));
                send(op, sew, 64'h7F01_80FF_0180_7FFF, 64'h80FF_7F00_8001_FF7F);
                send(op, sew, 64'h80FF_7F00_8001_FF7F, 64'h7F01_80FF_0180_7FFF);
                repeat (3) send(op, sew, rand_data(), rand_data());
            end
        end
        end_test("min_max");

        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            send(valu_op_e'(4'(r[31:24] % 8'd10)), valu_sew_e'(r[21:20]), rand_data(), rand_data());
            if (r[19] && r[18]) begin
                req_valid = 1'b0;  // bubble with live fields
            end
        end
        end_test("mixed_stream");

        for (int k = 10; k < 16; k++) begin
            send(valu_op_e'(4'(k)), SEW_8, rand_data(), rand_data());
            send(OP_ADD, SEW_16, rand_data(), rand_data());
        end
        end_test("bad_opcode");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/valu_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "valu_config.svh"

module valu_asserts (
    input wire                       clk,
    input wire                       rst,
    input wire                       req_valid,
    input wire valu_pkg::valu_op_e   req_op,
    input wire valu_pkg::valu_sew_e  req_sew,
    input wire valu_pkg::valu_data_t req_data0,
    input wire valu_pkg::valu_data_t req_data1,
    input wire valu_pkg::valu_be_t   req_be,
    input wire valu_pkg::valu_addr_t req_addr,
    input wire                       req_start,
    input wire                       req_end,
    input wire                       resp_valid,
    input wire valu_pkg::valu_data_t resp_data,
    input wire valu_pkg::valu_be_t   resp_be,
    input wire valu_pkg::valu_addr_t resp_addr,
    input wire                       resp_start,
    input wire                       resp_end
);

    import valu_pkg::*;

    localparam int DEPTH  = `VALU_LATENCY;  // one entry per DUT register stage
    localparam int SIDE_W = BE_W + ADDR_W + 2;
    localparam int EXP_W  = 1 + DATA_W + SIDE_W;

    logic [EXP_W-1:0]  exp_now;
    logic [EXP_W-1:0]  exp_q [DEPTH];
    logic              exp_valid;
    valu_data_t        exp_data;
    logic [SIDE_W-1:0] exp_side;
    int                valid_errs = 0;
    int                data_errs  = 0;
    int                side_errs  = 0;
    int                fail_count;  // read by the testbench

    function automatic valu_data_t model_result(input valu_op_e op, input valu_sew_e sew,
                                                input valu_data_t d0, input valu_data_t d1);
        int         w;
        valu_data_t mask;
        valu_data_t e0;
        valu_data_t e1;
        valu_data_t r;
        valu_data_t res;
        logic       lt;
        w    = 8 << sew;
        mask = (w == DATA_W) ? '1 : (64'd1 << w) - 64'd1;
        res  = '0;
        for (int e = 0; e < DATA_W / w; e++) begin
            e0 = (d0 >> (e * w)) & mask;
            e1 = (d1 >> (e * w)) & mask;
            // left aligned, so the 64-bit compare keeps the element order
            lt = (op inside {OP_MIN, OP_MAX})
               ? ($signed(e1 << (DATA_W - w)) < $signed(e0 << (DATA_W - w)))
               : (e1 < e0);
            case (op)
                OP_AND:          r = e1 & e0;
                OP_OR:           r = e1 | e0;
                OP_XOR:          r = e1 ^ e0;
                OP_ADD:          r = e1 + e0;
                OP_SUB:          r = e1 - e0;
                OP_RSUB:         r = e0 - e1;
                OP_MINU, OP_MIN: r = lt ? e1 : e0;
                OP_MAXU, OP_MAX: r = lt ? e0 : e1;
                default:         r = '0;
            endcase
            res = res | ((r & mask) << (e * w));  // wraps inside the element
        end
        return res;
    endfunction

    assign exp_now = (req_valid && (4'(req_op) < 4'd10))
                   ? {1'b1, model_result(req_op, req_sew, req_data0, req_data1),
                      req_be, req_addr, req_start, req_end}
                   : '0;
    assign exp_valid  = exp_q[DEPTH-1][EXP_W-1];
    assign exp_data   = exp_q[DEPTH-1][EXP_W-2 -: DATA_W];
    assign exp_side   = exp_q[DEPTH-1][SIDE_W-1:0];
    assign fail_count = valid_errs + data_errs + side_errs;

    always_ff @(posedge clk) begin
        exp_q[0] <= exp_now;
        for (int i = 1; i < DEPTH; i++) begin
            exp_q[i] <= exp_q[i-1];
        end
    end

    assert property (@(posedge clk) disable iff (rst) resp_valid == exp_valid)
        else begin
            valid_errs++;
            $error("[ERROR] %0t resp_valid expected %0b got %0b", $time, exp_valid, resp_valid);
        end

    assert property (@(posedge clk) disable iff (rst) resp_data == exp_data)
        else begin
            data_errs++;
            $error("[ERROR] %0t resp_data expected %h got %h", $time, exp_data, resp_data);
        end

    assert property (@(posedge clk) disable iff (rst)
                     {resp_be, resp_addr, resp_start, resp_end} == exp_side)
        else begin
            side_errs++;
            $error("[ERROR] %0t resp_be/addr/start/end expected %h got %h", $time, exp_side,
                   {resp_be, resp_addr, resp_start, resp_end});
        end

endmodule

bind valu_top valu_asserts asserts_i (.*);

`default_nettype wire

/* logic/valu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module valu_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req_valid,
    input  wire valu_pkg::valu_op_e   req_op,
    input  wire valu_pkg::valu_sew_e  req_sew,
    input  wire valu_pkg::valu_data_t req_data0,
    input  wire valu_pkg::valu_data_t req_data1,
    input  wire valu_pkg::valu_be_t   req_be,
    input  wire valu_pkg::valu_addr_t req_addr,
    input  wire                       req_start,
    input  wire                       req_end,
    output logic                      resp_valid,
    output valu_pkg::valu_data_t      resp_data,
    output valu_pkg::valu_be_t        resp_be,
    output valu_pkg::valu_addr_t      resp_addr,
    output logic                      resp_start,
    output logic                      resp_end
);

    import valu_pkg::*;

    logic       bit_valid;
    valu_data_t bit_data;
    logic       arith_valid;
    valu_data_t arith_data;

    valu_bitwise_unit bitwise_unit_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_op     (req_op),
        .in_data0  (req_data0),
        .in_data1  (req_data1),
        .out_valid (bit_valid),
        .out_data  (bit_data)
    );

    valu_arith_unit arith_unit_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_op     (req_op),
        .in_sew    (req_sew),
        .in_data0  (req_data0),
        .in_data1  (req_data1),
        .out_valid (arith_valid),
        .out_data  (arith_data)
    );

    valu_resp_merge resp_merge_i (
        .clk         (clk),
        .rst         (rst),
        .in_be       (req_be),
        .in_addr     (req_addr),
        .in_start    (req_start),
        .in_end      (req_end),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_be     (resp_be),
        .resp_addr   (resp_addr),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

endmodule

`default_nettype wire

/* logic/valu_resp_merge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "valu_config.svh"

module valu_resp_merge (
    input  wire                       clk,
    input  wire                       rst,
    input  wire valu_pkg::valu_be_t   in_be,
    input  wire valu_pkg::valu_addr_t in_addr,
    input  wire                       in_start,
    input  wire                       in_end,
    input  wire                       bit_valid,
    input  wire valu_pkg::valu_data_t bit_data,
    input  wire                       arith_valid,
    input  wire valu_pkg::valu_data_t arith_data,
    output logic                      resp_valid,
    output valu_pkg::valu_data_t      resp_data,
    output valu_pkg::valu_be_t        resp_be,
    output valu_pkg::valu_addr_t      resp_addr,
    output logic                      resp_start,
    output logic                      resp_end
);

    import valu_pkg::*;

    localparam int DEPTH = `VALU_UNIT_LATENCY;

    valu_be_t   be_q    [DEPTH];
    valu_addr_t addr_q  [DEPTH];
    logic       start_q [DEPTH];
    logic       end_q   [DEPTH];
    logic       any_valid;

    assign any_valid = bit_valid | arith_valid;  // groups never overlap

    // sideband delay, same depth as the units
    always_ff @(posedge clk) begin
        be_q[0]    <= in_be;
        addr_q[0]  <= in_addr;
        start_q[0] <= in_start;
        end_q[0]   <= in_end;
        for (int i = 1; i < DEPTH; i++) begin
            be_q[i]    <= be_q[i-1];
            addr_q[i]  <= addr_q[i-1];
            start_q[i] <= start_q[i-1];
            end_q[i]   <= end_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_be    <= '0;
            resp_addr  <= '0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= any_valid;
            resp_data  <= bit_data | arith_data;  // idle unit drives zero
            resp_be    <= any_valid ? be_q[DEPTH-1] : '0;
            resp_addr  <= any_valid ? addr_q[DEPTH-1] : '0;
            resp_start <= any_valid & start_q[DEPTH-1];
            resp_end   <= any_valid & end_q[DEPTH-1];
        end
    end

endmodule

`default_nettype wire

/* logic/valu_arith_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module valu_arith_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire valu_pkg::valu_op_e   in_op,
    input  wire valu_pkg::valu_sew_e  in_sew,
    input  wire valu_pkg::valu_data_t in_data0,
    input  wire valu_pkg::valu_data_t in_data1,
    output logic                      out_valid,
    output valu_pkg::valu_data_t      out_data
);

    import valu_pkg::*;

    logic            add_op;
    logic            is_sub;
    logic            is_signed;
    logic [2:0]      lane_mask;   // low lane index bits inside one element
    valu_data_t      opa;
    valu_data_t      opb;
    logic [BE_W-1:0] lane_cin;
    logic [BE_W:0]   lane_carry;
    logic [8:0]      lane_sum [BE_W];
    valu_data_t      sum;
    logic [BE_W-1:0] lt_top;      // only meaningful at the top lane of an element

    logic            s1_valid;
    valu_op_e        s1_op;
    valu_sew_e       s1_sew;
    valu_data_t      s1_data0;
    valu_data_t      s1_data1;
    valu_data_t      s1_sum;
    logic [BE_W-1:0] s1_lt;
    logic [2:0]      s1_lane_mask;
    logic            s1_minmax;
    logic            s1_max;
    logic [BE_W-1:0] take_data1;
    valu_data_t      result;

    assign add_op    = in_op inside {OP_ADD, OP_SUB, OP_RSUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX};
    assign is_sub    = in_op != OP_ADD;  // min/max use data1 - data0 too
    assign is_signed = in_op inside {OP_MIN, OP_MAX};
    assign lane_mask = ~(3'b111 << in_sew);

    // rsub swaps the operands
    assign opa = (in_op == OP_RSUB) ? in_data0 : in_data1;
    assign opb = (in_op == OP_RSUB) ? in_data1 : in_data0;

    // byte lanes, carry chain restarts at each element boundary
    always_comb begin
        lane_carry[0] = 1'b0;
        for (int k = 0; k < BE_W; k++) begin
            lane_cin[k]       = ((3'(k) & lane_mask) == 3'd0) ? is_sub : lane_carry[k];
            lane_sum[k]       = {1'b0, opa[k*8 +: 8]}
                              + {1'b0, (is_sub ? ~opb[k*8 +: 8] : opb[k*8 +: 8])}
                              + {8'h00, lane_cin[k]};
            sum[k*8 +: 8]     = lane_sum[k][7:0];
            lane_carry[k+1]   = lane_sum[k][8];
        end
    end

    // data1 < data0 per element, no carry out means borrow
    always_comb begin
        for (int k = 0; k < BE_W; k++) begin
            if (is_signed && (in_data1[k*8+7] != in_data0[k*8+7])) begin
                lt_top[k] = in_data1[k*8+7];
            end else begin
                lt_top[k] = ~lane_carry[k+1];
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_op    <= in_op;
        s1_sew   <= in_sew;
        s1_data0 <= in_data0;
        s1_data1 <= in_data1;
        s1_sum   <= sum;
        s1_lt    <= lt_top;
    end

    assign s1_lane_mask = ~(3'b111 << s1_sew);
    assign s1_minmax    = s1_op inside {OP_MINU, OP_MIN, OP_MAXU, OP_MAX};
    assign s1_max       = s1_op inside {OP_MAXU, OP_MAX};

    // spread the element flag over its lanes
    always_comb begin
        for (int k = 0; k < BE_W; k++) begin
            take_data1[k] = s1_lt[3'(k) | s1_lane_mask] ^ s1_max;
            if (!s1_minmax) begin
                result[k*8 +: 8] = s1_sum[k*8 +: 8];
            end else if (take_data1[k]) begin
                result[k*8 +: 8] = s1_data1[k*8 +: 8];
            end else begin
                result[k*8 +: 8] = s1_data0[k*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            s1_valid  <= in_valid & add_op;
            out_valid <= s1_valid;
            out_data  <= s1_valid ? result : '0;
        end
    end

endmodule

`default_nettype wire

/* logic/valu_bitwise_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module valu_bitwise_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire valu_pkg::valu_op_e   in_op,
    input  wire valu_pkg::valu_data_t in_data0,
    input  wire valu_pkg::valu_data_t in_data1,
    output logic                      out_valid,
    output valu_pkg::valu_data_t      out_data
);

    import valu_pkg::*;

    logic       bit_op;  // op belongs to this unit
    valu_data_t bit_res;
    logic       s1_valid;
    valu_data_t s1_data;

    always_comb begin
        bit_op = 1'b1;
        case (in_op)
            OP_AND: bit_res = in_data1 & in_data0;
            OP_OR:  bit_res = in_data1 | in_data0;
            OP_XOR: bit_res = in_data1 ^ in_data0;
            default: begin
                bit_op  = 1'b0;
                bit_res = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        s1_data <= bit_res;
    end

    // second stage only matches the arith unit latency
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            s1_valid  <= in_valid & bit_op;
            out_valid <= s1_valid;
            out_data  <= s1_valid ? s1_data : '0;  // zero when idle
        end
    end

endmodule

`default_nettype wire

/* logic/valu_pkg.sv */
`default_nettype none

`include "valu_config.svh"

package valu_pkg;

    localparam int DATA_W = `VALU_DATA_WIDTH;
    localparam int ADDR_W = `VALU_ADDR_WIDTH;
    localparam int BE_W   = `VALU_BE_WIDTH;  // also the number of byte lanes

    typedef enum logic [3:0] {
        OP_AND  = 4'd0,
        OP_OR   = 4'd1,
        OP_XOR  = 4'd2,
        OP_ADD  = 4'd3,
        OP_SUB  = 4'd4,
        OP_RSUB = 4'd5,
        OP_MINU = 4'd6,
        OP_MIN  = 4'd7,
        OP_MAXU = 4'd8,
        OP_MAX  = 4'd9
    } valu_op_e;  // codes 10 to 15 have no unit

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } valu_sew_e;

    typedef logic [DATA_W-1:0] valu_data_t;
    typedef logic [ADDR_W-1:0] valu_addr_t;
    typedef logic [BE_W-1:0]   valu_be_t;

endpackage

`default_nettype wire

/* logic/valu_config.svh */
`ifndef VALU_CONFIG_SVH
`define VALU_CONFIG_SVH

// one beat of operand or result data
`define VALU_DATA_WIDTH 64

// destination address of a beat
`define VALU_ADDR_WIDTH 32

`define VALU_BE_WIDTH (`VALU_DATA_WIDTH / 8)  // one enable per byte

// register stages inside each unit
`define VALU_UNIT_LATENCY 2

// request to response, the merge adds one stage
`define VALU_LATENCY (`VALU_UNIT_LATENCY + 1)

`endif
